// ==== Bender.yml ====
package:
  name: mvu_binary

sources:
  - source/mvu_pkg.sv
  - source/mvu_pe_simd_binary.sv
  - source/mvu_pe_adder_tree.sv
  - source/mvu_pe_acc.sv
  - source/mvu_pe.sv
  - source/mvu_wgt_mem.sv
  - source/mvu_control.sv
  - source/mvu_binary_top.sv
  - target: test
    files:
      - dv/mvu_binary_assertions.sv
      - dv/mvu_binary_tb.sv

// ==== compile.f ====
source/mvu_pkg.sv
source/mvu_pe_simd_binary.sv
source/mvu_pe_adder_tree.sv
source/mvu_pe_acc.sv
source/mvu_pe.sv
source/mvu_wgt_mem.sv
source/mvu_control.sv
source/mvu_binary_top.sv
dv/mvu_binary_assertions.sv
dv/mvu_binary_tb.sv

// ==== dv/mvu_binary_assertions.sv ====
// Top level strobe assertions
`timescale 1ns/1ps

module mvu_binary_assertions (
   input logic clk,
   input logic rst_n,
   input logic wgt_we,      // Host weight write
   input logic act_valid,   // Host beat strobe
   input logic beat_valid,  // Control to PEs
   input logic out_valid    // Result strobe
);

   // Strobes cleared by reset
   a_reset_low: assert property (@(posedge clk) !rst_n |=> !out_valid && !beat_valid)
      else $error("Strobe high after a reset edge");

   // Known once reset was driven
   a_known: assert property (@(posedge clk)
      !$isunknown(rst_n) |=> !$isunknown({out_valid, beat_valid}))
      else $error("Strobe is unknown");

   // One cycle per neuron fold
   a_single: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |=> !out_valid)
      else $error("out_valid held for two cycles");

   // Host writes only between vectors
   a_exclusive: assert property (@(posedge clk) !(act_valid && wgt_we))
      else $error("act_valid and wgt_we high together");

endmodule

bind mvu_binary_top mvu_binary_assertions assertions_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .wgt_we    (wgt_we),
   .act_valid (act_valid),
   .beat_valid(beat_valid),
   .out_valid (out_valid)
);

// ==== dv/mvu_binary_tb.sv ====
// Binary MVU testbench
`timescale 1ns/1ps

module mvu_binary_tb
   import mvu_pkg::*;
();

   typedef act_t     [MAT_COLS-1:0] act_row_t;     // One full activation vector
   typedef acc_vec_t [NF-1:0]       vec_result_t;  // Both neuron folds of a vector

   localparam int NUM_RAND       = 10;       // Vectors in tests 1 and 3
   localparam int VEC_BEATS      = NF * SF;  // Beats per vector
   localparam int LATENCY        = 4;        // Last beat to out_valid
   localparam int TOTAL_BEATS    = (NUM_RAND + 3 + NUM_RAND + 2 + 1) * VEC_BEATS + (SF + 1);
   localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 2 + 200;  // Gaps at most double

   localparam int FILL_ZERO = 0;  // All weights -1
   localparam int FILL_ONES = 1;  // All weights +1
   localparam int FILL_ALT  = 2;  // Alternating bits, address mixed in
   localparam int FILL_RAND = 3;  // From rand_wgts

   logic      clk;
   logic      rst_n;
   logic      wgt_we;
   logic      act_valid;
   wgt_addr_t wgt_addr;
   wgt_word_t wgt_data;
   act_vec_t  act_data;
   logic      out_valid;
   acc_vec_t  out_data;

   wgt_word_t   wgt_model [WGT_DEPTH];  // Mirror of the weight memory
   wgt_word_t   rand_wgts [WGT_DEPTH];  // Current random weight set
   act_row_t    vec_store [NUM_RAND];   // Test 1 vectors, reused in test 3
   acc_vec_t    exp_q [$];              // Expected results in order
   int unsigned accept_q [$];           // Edge count of each last beat
   int unsigned cycle_cnt = 0;          // Rising edges seen
   integer      seed = 32'h389d_c33a;

   mvu_binary_top dut_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wgt_we   (wgt_we),
      .act_valid(act_valid),
      .wgt_addr (wgt_addr),
      .wgt_data (wgt_data),
      .act_data (act_data),
      .out_valid(out_valid),
      .out_data (out_data)
   );

   always #50 clk = ~clk;  // 100 ns period

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_acc_vec(input acc_vec_t expected, input acc_vec_t got);
      int bad;
      bad = -1;
      for (int p = PE - 1; p >= 0; p--) begin
         if (got[p] !== expected[p]) bad = p;  // Lowest failing PE
      end
      if (bad >= 0) begin
         $display("ERROR: out_data[%0d] expected %h got %h", bad, expected[bad], got[bad]);
         abort_run("Row result does not match the reference");
      end
   endtask

   task automatic check_latency(input int unsigned accept_cycle);
      if (cycle_cnt - accept_cycle != LATENCY) begin
         $display("ERROR: out_valid latency expected %h got %h",
                  LATENCY, cycle_cnt - accept_cycle);
         abort_run("Result strobe came at the wrong cycle");
      end
   endtask

   // Weight 1 adds the activation, weight 0 subtracts it
   function automatic vec_result_t mvm_reference(input act_row_t acts,
                                                 input wgt_word_t wgts [WGT_DEPTH]);
      vec_result_t res;
      int          sum;
      int          col;
      logic        wbit;
      for (int nf = 0; nf < NF; nf++) begin
         for (int p = 0; p < PE; p++) begin
            sum = 0;
            for (int sf = 0; sf < SF; sf++) begin
               for (int i = 0; i < SIMD; i++) begin
                  col  = sf * SIMD + i;
                  wbit = wgts[nf * SF + sf][p * SIMD + i];  // Row nf*PE + p
                  sum  = wbit ? sum + int'(acts[col]) : sum - int'(acts[col]);
               end
            end
            res[nf][p] = acc_t'(sum);
         end
      end
      return res;
   endfunction

   function automatic act_row_t random_vector();
      act_row_t v;
      for (int c = 0; c < MAT_COLS; c++) begin
         v[c] = act_t'($random(seed));
      end
      return v;
   endfunction

   task automatic draw_random_weights();
      for (int a = 0; a < WGT_DEPTH; a++) begin
         rand_wgts[a] = wgt_word_t'($random(seed));
      end
   endtask

   task automatic write_weight(input wgt_addr_t addr, input wgt_word_t data);
      @(negedge clk);
      act_valid       = 1'b0;
      wgt_we          = 1'b1;
      wgt_addr        = addr;
      wgt_data        = data;
      wgt_model[addr] = data;  // Keep model in step
   endtask

   task automatic fill_weights(input int kind);
      wgt_word_t word;
      for (int a = 0; a < WGT_DEPTH; a++) begin
         case (kind)
            FILL_ZERO: word = '0;
            FILL_ONES: word = '1;
            FILL_ALT:  word = 8'h55 ^ {wgt_addr_t'(a), 2'b00, wgt_addr_t'(a)};
            default:   word = rand_wgts[a];
         endcase
         write_weight(wgt_addr_t'(a), word);
      end
      @(negedge clk);
      wgt_we = 1'b0;
   endtask

   // Leaves act_valid high so the next call runs back to back
   task automatic stream_beats(input act_row_t acts, input int nbeats, input bit gaps);
      int sf;
      int gap;
      for (int k = 0; k < nbeats; k++) begin
         sf = k % SF;  // nf outer, sf inner
         @(negedge clk);
         act_valid = 1'b1;
         act_data  = acts[sf * SIMD +: SIMD];
         if (sf == SF - 1) begin
            accept_q.push_back(cycle_cnt + 1);  // Taken at the coming edge
         end
         gap = gaps ? ($random(seed) & 1) : 0;
         repeat (gap) begin
            @(negedge clk);
            act_valid = 1'b0;  // Idle cycle
         end
      end
   endtask

   task automatic send_vector(input act_row_t acts, input bit gaps);
      vec_result_t res;
      res = mvm_reference(acts, wgt_model);
      for (int nf = 0; nf < NF; nf++) begin
         exp_q.push_back(res[nf]);
      end
      stream_beats(acts, VEC_BEATS, gaps);
   endtask

   task automatic drain_results();
      @(negedge clk);
      act_valid = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // Timeout guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   // Compare on the falling edge, outputs settled
   always @(negedge clk) begin
      if (!rst_n) begin
         if (out_valid === 1'b1) abort_run("out_valid was high while reset was asserted");
      end else if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            abort_run("out_valid came with no result expected");
         end else begin
            check_acc_vec(exp_q.pop_front(), out_data);
            check_latency(accept_q.pop_front());
         end
      end
   end

   initial begin
      act_row_t    v;
      vec_result_t res;
      clk       = 1'b0;
      rst_n     = 1'b0;
      wgt_we    = 1'b0;
      act_valid = 1'b0;
      wgt_addr  = '0;
      wgt_data  = '0;
      act_data  = '0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      $display("Test 1: random weights, vectors back to back");
      draw_random_weights();
      fill_weights(FILL_RAND);
      for (int n = 0; n < NUM_RAND; n++) begin
         vec_store[n] = random_vector();
         send_vector(vec_store[n], 1'b0);
      end
      drain_results();

      $display("Test 2: extreme and alternating values");
      for (int c = 0; c < MAT_COLS; c++) v[c] = act_t'(-8);
      fill_weights(FILL_ZERO);
      res = mvm_reference(v, wgt_model);
      if (res !== {NF * PE{acc_t'(128)}}) abort_run("Minus weights did not predict +128");
      send_vector(v, 1'b0);
      drain_results();
      fill_weights(FILL_ONES);
      res = mvm_reference(v, wgt_model);
      if (res !== {NF * PE{acc_t'(-128)}}) abort_run("Plus weights did not predict -128");
      send_vector(v, 1'b0);
      drain_results();
      for (int c = 0; c < MAT_COLS; c++) v[c] = c[0] ? act_t'(7) : act_t'(-8);
      fill_weights(FILL_ALT);
      send_vector(v, 1'b0);
      drain_results();

      $display("Test 3: test 1 data with idle gaps");
      fill_weights(FILL_RAND);
      for (int n = 0; n < NUM_RAND; n++) begin
         send_vector(vec_store[n], 1'b1);
      end
      drain_results();

      $display("Test 4: weights rewritten between vectors");
      v = random_vector();
      send_vector(v, 1'b0);
      drain_results();
      draw_random_weights();
      fill_weights(FILL_RAND);
      send_vector(v, 1'b0);
      drain_results();

      $display("Test 5: reset in the middle of a vector");
      v   = random_vector();
      res = mvm_reference(v, wgt_model);
      exp_q.push_back(res[0]);  // First fold in flight when reset hits
      stream_beats(v, SF + 1, 1'b0);
      @(negedge clk);
      act_valid = 1'b0;
      rst_n     = 1'b0;
      exp_q.delete();  // Nothing of the cut vector may come out
      accept_q.delete();
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      send_vector(v, 1'b0);  // Must start again at fold zero
      drain_results();

      if (exp_q.size() != 0) begin
         abort_run($sformatf("%0d expected results never arrived", exp_q.size()));
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// ==== source/mvu_binary_top.sv ====
// Binary matrix-vector unit top
`timescale 1ns/1ps

module mvu_binary_top
   import mvu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      wgt_we,     // Weight write strobe
   input  logic      act_valid,  // Activation beat strobe
   input  wgt_addr_t wgt_addr,   // Weight write address
   input  wgt_word_t wgt_data,   // Weight write word
   input  act_vec_t  act_data,   // Activation beat
   output logic      out_valid,  // Neuron fold result strobe
   output acc_vec_t  out_data    // PE rows of one neuron fold
);

   wgt_addr_t       rd_addr;     // Control to memory
   wgt_word_t       rd_data;     // Memory to PEs
   logic            beat_valid;  // Control to PEs
   pe_beat_t        beat;
   logic [PE-1:0]   pe_valid;    // All PEs strobe together

   mvu_control ctrl_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .act_valid (act_valid),
      .act_data  (act_data),
      .rd_addr   (rd_addr),
      .beat_valid(beat_valid),
      .beat      (beat)
   );

   mvu_wgt_mem mem_i (
      .clk  (clk),
      .we   (wgt_we),
      .waddr(wgt_addr),
      .raddr(rd_addr),
      .wdata(wgt_data),
      .rdata(rd_data)
   );

   for (genvar p = 0; p < PE; p++) begin : g_pe
      mvu_pe pe_i (
         .clk       (clk),
         .rst_n     (rst_n),
         .beat_valid(beat_valid),
         .beat      (beat),
         .wgts      (rd_data[p*SIMD +: SIMD]),  // PE p slice
         .acc       (out_data[p]),              // Row nf*PE + p
         .out_valid (pe_valid[p])
      );
   end

   assign out_valid = pe_valid[0];  // PE 0 speaks for all

endmodule

// ==== source/mvu_control.sv ====
// Fold control and beat staging
`timescale 1ns/1ps

module mvu_control
   import mvu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      act_valid,   // Host beat strobe
   input  act_vec_t  act_data,    // Host activations
   output wgt_addr_t rd_addr,     // Weight read address
   output logic      beat_valid,  // Beat strobe to the PEs
   output pe_beat_t  beat         // Beat to the PEs
);

   logic [$clog2(SF)-1:0] sf_q;        // Synapse fold counter
   logic [$clog2(NF)-1:0] nf_q;        // Neuron fold counter
   wgt_addr_t             fold_addr;   // nf*SF + sf
   logic                  stage_vld;   // First stage valid
   pe_beat_t              stage_beat;  // First stage beat

   assign fold_addr = wgt_addr_t'(nf_q * SF + sf_q);

   // Fold counters, sf inner, nf outer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sf_q <= '0;
         nf_q <= '0;
      end else if (act_valid) begin
         if (sf_q == SF - 1) begin
            sf_q <= '0;  // Wrap, next row group
            nf_q <= (nf_q == NF - 1) ? '0 : nf_q + 1'b1;
         end else begin
            sf_q <= sf_q + 1'b1;
         end
      end
   end

   // Valid pipeline
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage_vld  <= 1'b0;
         beat_valid <= 1'b0;
      end else begin
         stage_vld  <= act_valid;
         beat_valid <= stage_vld;  // Meets memory read data
      end
   end

   // Payload, address goes out while beat waits a stage
   always_ff @(posedge clk) begin
      if (act_valid) begin
         rd_addr          <= fold_addr;
         stage_beat.acts  <= act_data;
         stage_beat.first <= (sf_q == 0);
         stage_beat.last  <= (sf_q == SF - 1);
      end
      beat <= stage_beat;  // Aligned with rdata
   end

endmodule

// ==== source/mvu_pe.sv ====
// Processing element
`timescale 1ns/1ps

module mvu_pe
   import mvu_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            beat_valid,  // Beat strobe from control
   input  pe_beat_t        beat,        // Activations and fold flags
   input  logic [SIMD-1:0] wgts,        // This PE's weight slice
   output acc_t            acc,         // Row result
   output logic            out_valid    // Row result strobe
);

   prod_t [SIMD-1:0] prods;  // Lane outputs
   sum_t             sum;    // Tree output
   logic [1:0]       vld_d;    // Valid delay line
   logic [1:0]       first_d;  // First flag delay line
   logic [1:0]       last_d;   // Last flag delay line

   // SIMD lanes
   for (genvar i = 0; i < SIMD; i++) begin : g_lane
      mvu_pe_simd_binary #(
         .TO(PROD_W)
      ) lane_i (
         .clk   (clk),
         .rst_n (rst_n),
         .in_act(beat.acts[i]),  // Activation i
         .in_wgt(wgts[i]),       // Weight bit i
         .out   (prods[i])
      );
   end

   mvu_pe_adder_tree tree_i (
      .clk  (clk),
      .rst_n(rst_n),
      .prods(prods),
      .sum  (sum)
   );

   // Two stages, matches lane plus tree latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_d <= '0;
      end else begin
         vld_d <= {vld_d[0], beat_valid};
      end
   end

   always_ff @(posedge clk) begin
      first_d <= {first_d[0], beat.first};  // Flags qualified by vld_d
      last_d  <= {last_d[0], beat.last};
   end

   mvu_pe_acc acc_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (vld_d[1]),
      .first    (first_d[1]),
      .last     (last_d[1]),
      .sum      (sum),
      .acc      (acc),
      .out_valid(out_valid)
   );

endmodule

// ==== source/mvu_pe_acc.sv ====
// PE fold accumulator
`timescale 1ns/1ps

module mvu_pe_acc
   import mvu_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic in_valid,   // Tree sum is valid
   input  logic first,      // First synapse fold, load
   input  logic last,       // Last synapse fold, emit
   input  sum_t sum,        // Tree total
   output acc_t acc,        // Running row sum
   output logic out_valid   // One cycle after a last sum
);

   acc_t sum_ext;  // Tree total at accumulator width

   assign sum_ext = acc_t'(sum);  // Sign extension

   // Accumulator register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (in_valid) begin
         if (first) begin
            acc <= sum_ext;  // New row group, drop old total
         end else begin
            acc <= acc + sum_ext;  // Add next fold
         end
      end
   end

   // Result strobe, aligned with final acc
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid & last;  // Single-cycle pulse
      end
   end

endmodule

// ==== source/mvu_pe_adder_tree.sv ====
// PE adder tree
`timescale 1ns/1ps

module mvu_pe_adder_tree
   import mvu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  prod_t [SIMD-1:0]      prods,  // Lane products
   output sum_t                  sum     // Registered total
);

   logic signed [PROD_W:0] lvl1 [SIMD/2];  // Pairwise sums, one bit growth
   sum_t                   lvl2;           // Final total, one more bit

   // Two combinational levels for four lanes
   always_comb begin
      for (int i = 0; i < SIMD / 2; i++) begin
         lvl1[i] = (PROD_W + 1)'(prods[2*i]) + (PROD_W + 1)'(prods[2*i+1]);
      end
      lvl2 = SUM_W'(lvl1[0]) + SUM_W'(lvl1[1]);  // Sign-extended add
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sum <= '0;
      end else begin
         sum <= lvl2;  // One register stage after the lanes
      end
   end

endmodule

// ==== source/mvu_pe_simd_binary.sv ====
// Binary weight SIMD lane
`timescale 1ns/1ps

module mvu_pe_simd_binary
   import mvu_pkg::*;
#(
   parameter int TO = PROD_W  // Product width
) (
   input  logic          clk,
   input  logic          rst_n,
   input  act_t          in_act,  // Signed activation
   input  logic          in_wgt,  // 1 is +1, 0 is -1
   output logic [TO-1:0] out      // Registered product
);

   logic [TO-1:0] act_ext;  // Sign-extended activation

   assign act_ext = TO'(in_act);  // Cast keeps sign

   // Multiply by +-1 is pass or two's complement
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out <= '0;
      end else if (in_wgt == 1'b1) begin
         out <= act_ext;  // Weight +1
      end else begin
         out <= ~act_ext + 1'b1;  // Weight -1
      end
   end

endmodule

// ==== source/mvu_pkg.sv ====
// Binary MVU shared definitions
package mvu_pkg;

   // Geometry
   localparam int SIMD      = 4;   // Lanes per PE
   localparam int PE        = 2;   // Processing elements
   localparam int SF        = 4;   // Synapse folds
   localparam int NF        = 2;   // Neuron folds
   localparam int MAT_ROWS  = 4;   // NF * PE
   localparam int MAT_COLS  = 16;  // SF * SIMD
   localparam int WGT_DEPTH = 8;   // NF * SF words

   // Datapath widths
   localparam int ACT_W  = 4;   // Signed activation
   localparam int PROD_W = 5;   // Negated -8 still fits
   localparam int SUM_W  = 7;   // Four products, two adder levels
   localparam int ACC_W  = 10;  // Holds +-128

   typedef logic signed [ACT_W-1:0]  act_t;      // One activation
   typedef act_t        [SIMD-1:0]   act_vec_t;  // One beat of activations
   typedef logic signed [PROD_W-1:0] prod_t;     // Lane product
   typedef logic signed [SUM_W-1:0]  sum_t;      // Adder tree total
   typedef logic signed [ACC_W-1:0]  acc_t;      // Row accumulator

   // PE p owns bits p*SIMD upward, lane i is bit i of that slice
   typedef logic [PE*SIMD-1:0] wgt_word_t;

   // Address is nf*SF + sf
   typedef logic [$clog2(WGT_DEPTH)-1:0] wgt_addr_t;

   // Element p is matrix row nf*PE + p
   typedef acc_t [PE-1:0] acc_vec_t;

   // Beat from control to every PE
   typedef struct packed {
      act_vec_t acts;   // SIMD activations
      logic     first;  // First synapse fold of the row group
      logic     last;   // Last synapse fold
   } pe_beat_t;

endpackage

// ==== source/mvu_wgt_mem.sv ====
// Weight memory
`timescale 1ns/1ps

module mvu_wgt_mem
   import mvu_pkg::*;
(
   input  logic      clk,
   input  logic      we,     // Host write strobe
   input  wgt_addr_t waddr,  // Host write address
   input  wgt_addr_t raddr,  // Control read address
   input  wgt_word_t wdata,  // Host write word
   output wgt_word_t rdata   // Registered read word
);

   wgt_word_t mem [WGT_DEPTH];  // One word per fold pair

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, one cycle
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];  // Old data on same-address write
   end

endmodule
